// File: include/shaper_defs.svh
/* Pulse shaper widths and ratios */

`ifndef SHAPER_DEFS_SVH
`define SHAPER_DEFS_SVH

// Bits per rail of each incoming complex sample
`define SHAPER_IW 16
// Bits of each filter coefficient
`define SHAPER_CW 12
// Bits per rail of each filtered output
`define SHAPER_OW 24

// Outputs produced for every accepted input
`define SHAPER_NUP 4
// Taps summed for each output phase
`define SHAPER_TAPS 8
`define SHAPER_NCOEFFS (`SHAPER_NUP * `SHAPER_TAPS)
`define SHAPER_LG_NCOEFFS 5
`define SHAPER_LG_TAPS 3

// Guard bits dropped above the output window
`define SHAPER_SHIFT 2
// Room for a full product plus the growth of an eight tap sum
`define SHAPER_AW (`SHAPER_IW + `SHAPER_CW + `SHAPER_LG_TAPS)

`endif

// File: rtl/shaper_sample_pkg.sv
/* Pulse shaper signal path types */

`include "shaper_defs.svh"

package shaper_sample_pkg;

	// One complex input sample, I in the upper half of the packed word
	typedef struct packed {
		logic signed [`SHAPER_IW-1:0] i;
		logic signed [`SHAPER_IW-1:0] q;
	} iq_sample_t;

	// Full precision products of a sample and one coefficient
	typedef struct packed {
		logic signed [`SHAPER_IW+`SHAPER_CW-1:0] i;
		logic signed [`SHAPER_IW+`SHAPER_CW-1:0] q;
	} iq_product_t;

	// Running sums over the taps of one phase
	typedef struct packed {
		logic signed [`SHAPER_AW-1:0] i;
		logic signed [`SHAPER_AW-1:0] q;
	} iq_acc_t;

	// Rounded and clamped output pair
	typedef struct packed {
		logic signed [`SHAPER_OW-1:0] i;
		logic signed [`SHAPER_OW-1:0] q;
	} iq_result_t;

endpackage

// File: rtl/shaper_ctrl_pkg.sv
/* Pulse shaper control types */

`include "shaper_defs.svh"

package shaper_ctrl_pkg;

	// A single filter coefficient, shared by both rails
	typedef logic signed [`SHAPER_CW-1:0] coeff_t;

	// Address into the coefficient ring
	typedef logic [`SHAPER_LG_NCOEFFS-1:0] coeff_idx_t;

	// Address into the sample history ring
	typedef logic [`SHAPER_LG_TAPS-1:0] hist_idx_t;

	// Marks that ride alongside each tap through the pipeline
	// The first flag restarts the sum and the last flag closes it
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
	} tap_ctl_t;

	// One tap request as issued by the sequencer
	typedef struct packed {
		tap_ctl_t   ctl;
		coeff_idx_t coeff_addr;
		hist_idx_t  hist_addr;
	} tap_req_t;

endpackage

// File: rtl/tap_ram.sv
`timescale 1ns/1ps
/* Ring memory with write pointer */

module tap_ram
#(
	parameter type T_DATA   = logic,
	parameter int  DEPTH_LG = 3
)
(
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_wr,
	input  T_DATA               i_wr_data,
	input  logic [DEPTH_LG-1:0] i_rd_addr,
	output T_DATA               o_rd_data,
	output logic [DEPTH_LG-1:0] o_last_wr
);

	// Ring storage with one payload word per slot
	T_DATA mem [0:(1 << DEPTH_LG)-1];

	// Next slot to be written wraps around the ring on its own
	logic [DEPTH_LG-1:0] wr_ptr;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wr_ptr <= '0;
		else if (i_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_wr)
			mem[wr_ptr] <= i_wr_data;
	end

	// Read data appears one clock after the address
	always_ff @(posedge i_clk)
	begin
		o_rd_data <= mem[i_rd_addr];
	end

	// The slot just behind the pointer is the newest entry
	assign o_last_wr = wr_ptr - 1'b1;

endmodule

// File: rtl/tap_sequencer.sv
`timescale 1ns/1ps
/* Polyphase tap sequencer */

`include "shaper_defs.svh"

module tap_sequencer
	import shaper_ctrl_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_reset,
	input  logic      i_valid,
	input  hist_idx_t i_newest,
	output logic      o_ready,
	output logic      o_take,
	output tap_req_t  o_req
);

	localparam int LG_NUP = $clog2(`SHAPER_NUP);

	// Counters hold the phase and tap of the next request to issue
	logic                       running;
	logic [LG_NUP-1:0]          phase;
	logic [`SHAPER_LG_TAPS-1:0] tap;

	// Phase, tap and newest history slot used for the request this clock
	logic [LG_NUP-1:0]          req_phase;
	logic [`SHAPER_LG_TAPS-1:0] req_tap;
	hist_idx_t                  base;

	// Counter values after this request
	logic [LG_NUP-1:0]          next_phase;
	logic [`SHAPER_LG_TAPS-1:0] next_tap;
	logic                       done;
	tap_req_t                   next_req;

	// Only one sample is in work at a time
	assign o_ready = !running;
	assign o_take  = i_valid && o_ready;

	// Counters come back to zero once the last tap of the last phase is out
	assign done = (phase == '0) && (tap == '0);

	////////////////////
	// Request build
	////////////////////

	always_comb
	begin
		// A take starts at phase 0 tap 0 on the slot being written right now
		if (o_take)
		begin
			req_phase = '0;
			req_tap   = '0;
			base      = i_newest + hist_idx_t'(1);
		end
		else
		begin
			req_phase = phase;
			req_tap   = tap;
			base      = i_newest;
		end

		if (req_tap == `SHAPER_LG_TAPS'(`SHAPER_TAPS - 1))
		begin
			next_tap   = '0;
			next_phase = (req_phase == LG_NUP'(`SHAPER_NUP - 1)) ? '0 : req_phase + 1'b1;
		end
		else
		begin
			next_tap   = req_tap + 1'b1;
			next_phase = req_phase;
		end

		next_req.ctl.valid  = 1'b1;
		next_req.ctl.first  = (req_tap == '0);
		next_req.ctl.last   = (req_tap == `SHAPER_LG_TAPS'(`SHAPER_TAPS - 1));
		// Coefficient h[p + j*NUP] pairs with history x[n - j], newest first
		next_req.coeff_addr = coeff_idx_t'(req_phase)
			+ coeff_idx_t'(req_tap) * coeff_idx_t'(`SHAPER_NUP);
		next_req.hist_addr  = base - hist_idx_t'(req_tap);
	end

	////////////////////
	// Sequencing
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			running <= 1'b0;
			phase   <= '0;
			tap     <= '0;
			o_req   <= '0;
		end
		else if (o_take || (running && !done))
		begin
			running <= 1'b1;
			phase   <= next_phase;
			tap     <= next_tap;
			o_req   <= next_req;
		end
		else
		begin
			// Idle cycle after the last tap, ready returns here
			running <= 1'b0;
			o_req.ctl <= '0;
		end
	end

endmodule

// File: rtl/iq_mac.sv
`timescale 1ns/1ps
/* Paired I/Q multiply accumulate */

`include "shaper_defs.svh"

module iq_mac
	import shaper_sample_pkg::*;
	import shaper_ctrl_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  tap_ctl_t   i_ctl,
	input  iq_sample_t i_sample,
	input  coeff_t     i_coeff,
	output logic       o_sum_valid,
	output iq_acc_t    o_sum
);

	localparam int AW = `SHAPER_AW;

	// Control delayed by the memory read, then by the multiply
	tap_ctl_t    ctl_rd;
	tap_ctl_t    ctl_mul;
	iq_product_t prod;
	iq_acc_t     acc;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ctl_rd      <= '0;
			ctl_mul     <= '0;
			o_sum_valid <= 1'b0;
		end
		else
		begin
			ctl_rd      <= i_ctl;
			ctl_mul     <= ctl_rd;
			// The sum is complete once the last tap has been added
			o_sum_valid <= ctl_mul.valid && ctl_mul.last;
		end
	end

	// One shared multiply step, a single coefficient feeds both rails
	always_ff @(posedge i_clk)
	begin
		prod.i <= i_sample.i * i_coeff;
		prod.q <= i_sample.q * i_coeff;
	end

	// First tap of a phase restarts the sum, the others add onto it
	always_ff @(posedge i_clk)
	begin
		if (ctl_mul.valid && ctl_mul.first)
		begin
			acc.i <= AW'(prod.i);
			acc.q <= AW'(prod.q);
		end
		else if (ctl_mul.valid)
		begin
			acc.i <= acc.i + AW'(prod.i);
			acc.q <= acc.q + AW'(prod.q);
		end
	end

	assign o_sum = acc;

endmodule

// File: rtl/iq_round_sat.sv
`timescale 1ns/1ps
/* Output rounding and clamp */

`include "shaper_defs.svh"

module iq_round_sat
	import shaper_sample_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_sum_valid,
	input  iq_acc_t    i_sum,
	output logic       o_ce,
	output iq_result_t o_result
);

	localparam int AW   = `SHAPER_AW;
	localparam int OW   = `SHAPER_OW;
	// Low bits that the output window leaves behind
	localparam int DROP = AW - `SHAPER_SHIFT - OW;
	// Just under one half of an output step
	localparam logic [AW:0] HALF_M1 = (AW + 1)'((1 << (DROP - 1)) - 1);

	// Round half to even, then clamp into the signed output range
	function automatic logic signed [OW-1:0] round_sat(input logic signed [AW-1:0] v);
		logic [AW:0]         ext;
		logic [AW-DROP:0]    kept;
		logic [AW-DROP-OW+1:0] top;
		logic [OW-1:0]       res;
		// One extra bit on top keeps the rounding add from wrapping
		// Adding the kept LSB on a tie carries only when that LSB is odd
		ext  = {v[AW-1], v} + HALF_M1 + (AW + 1)'(v[DROP]);
		kept = ext[AW:DROP];
		top  = kept[AW-DROP:OW-1];
		if ((&top) || !(|top))
			res = kept[OW-1:0];
		else if (kept[AW-DROP])
			res = {1'b1, {(OW - 1){1'b0}}};
		else
			res = {1'b0, {(OW - 1){1'b1}}};
		return res;
	endfunction

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ce <= 1'b0;
		else
			o_ce <= i_sum_valid;
	end

	// Result holds between strobes
	always_ff @(posedge i_clk)
	begin
		if (i_sum_valid)
		begin
			o_result.i <= round_sat(i_sum.i);
			o_result.q <= round_sat(i_sum.q);
		end
	end

endmodule

// File: rtl/pulse_shaper_top.sv
`timescale 1ns/1ps
/* I/Q pulse shaping upsampler */

`include "shaper_defs.svh"

module pulse_shaper_top
	import shaper_sample_pkg::*;
	import shaper_ctrl_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_wr_coeff,
	input  coeff_t     i_coeff,
	input  logic       i_valid,
	input  iq_sample_t i_sample,
	output logic       o_ready,
	output logic       o_ce,
	output iq_result_t o_result
);

	logic       take;
	hist_idx_t  newest;
	tap_req_t   req;
	coeff_t     coeff_rd;
	iq_sample_t hist_rd;
	logic       sum_valid;
	iq_acc_t    sum;

	////////////////////
	// Input side
	////////////////////

	// Coefficients load through their own wrapping pointer
	tap_ram #(
		.T_DATA   (coeff_t),
		.DEPTH_LG (`SHAPER_LG_NCOEFFS)
	) u_coeff_ram (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_wr      (i_wr_coeff),
		.i_wr_data (i_coeff),
		.i_rd_addr (req.coeff_addr),
		.o_rd_data (coeff_rd),
		.o_last_wr ()
	);

	// Sample history, written once per accepted input
	tap_ram #(
		.T_DATA   (iq_sample_t),
		.DEPTH_LG (`SHAPER_LG_TAPS)
	) u_hist_ram (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_wr      (take),
		.i_wr_data (i_sample),
		.i_rd_addr (req.hist_addr),
		.o_rd_data (hist_rd),
		.o_last_wr (newest)
	);

	tap_sequencer u_tap_sequencer (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_valid  (i_valid),
		.i_newest (newest),
		.o_ready  (o_ready),
		.o_take   (take),
		.o_req    (req)
	);

	////////////////////
	// Processing and output
	////////////////////

	iq_mac u_iq_mac (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_ctl       (req.ctl),
		.i_sample    (hist_rd),
		.i_coeff     (coeff_rd),
		.o_sum_valid (sum_valid),
		.o_sum       (sum)
	);

	iq_round_sat u_iq_round_sat (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_sum_valid (sum_valid),
		.i_sum       (sum),
		.o_ce        (o_ce),
		.o_result    (o_result)
	);

endmodule

// File: bench/tb_pulse_shaper.sv
`timescale 1ns/1ps
/* Pulse shaper testbench */

`include "shaper_defs.svh"

module tb_pulse_shaper
	import shaper_sample_pkg::*;
	import shaper_ctrl_pkg::*;
();

	localparam int PERIOD = 40;
	localparam int NCO    = `SHAPER_NCOEFFS;
	localparam int IW     = `SHAPER_IW;
	localparam int CW     = `SHAPER_CW;
	localparam int OW     = `SHAPER_OW;
	// One output step is 2^5 accumulator units at the default widths
	localparam int DROP   = `SHAPER_AW - `SHAPER_SHIFT - `SHAPER_OW;
	// Upper bound on samples over all tests, each one busy for a full window plus holds
	localparam int N_SAMPLES   = 120;
	localparam int WATCHDOG_NS = (N_SAMPLES * (NCO + 24) + 600) * PERIOD;

	logic       i_clk = 1'b0;
	logic       i_reset;
	logic       i_wr_coeff;
	coeff_t     i_coeff;
	logic       i_valid;
	iq_sample_t i_sample;
	logic       o_ready;
	logic       o_ce;
	iq_result_t o_result;

	// Model state, newest history entry at index 0
	coeff_t     coef_model [NCO];
	iq_sample_t hist_model [`SHAPER_TAPS];
	coeff_idx_t wr_ptr_model;
	iq_result_t exp_q [$];
	logic       checking;
	int         seed = 16;
	int         value_errors = 0;
	int         other_errors = 0;
	int         sent_count = 0;
	int         take_count = 0;
	int         ce_count = 0;
	int         busy_cnt = 0;

	always #(PERIOD / 2) i_clk = ~i_clk;

	pulse_shaper_top dut (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wr_coeff (i_wr_coeff),
		.i_coeff    (i_coeff),
		.i_valid    (i_valid),
		.i_sample   (i_sample),
		.o_ready    (o_ready),
		.o_ce       (o_ce),
		.o_result   (o_result)
	);

	////////////////////
	// Reference model
	////////////////////

	// Divide by one output step with round half to even, then clamp to 24 signed bits
	function automatic logic signed [OW-1:0] scale_round(input longint s);
		longint q;
		longint r;
		longint half;
		longint maxv;
		half = longint'(1) << (DROP - 1);
		maxv = (longint'(1) << (OW - 1)) - 1;
		q = s >>> DROP;
		r = s - (q <<< DROP);
		if ((r > half) || ((r == half) && ((q & 1) != 0)))
			q = q + 1;
		if (q > maxv)
			q = maxv;
		else if (q < -maxv - 1)
			q = -maxv - 1;
		return OW'(q);
	endfunction

	// Phase p sums h[p + 4j] * x[n - j] over the eight taps, per rail
	function automatic iq_result_t expected_output(input int phase);
		longint     sum_i;
		longint     sum_q;
		longint     h;
		iq_result_t res;
		sum_i = 0;
		sum_q = 0;
		for (int j = 0; j < `SHAPER_TAPS; j++)
		begin
			h = longint'(coef_model[phase + j * `SHAPER_NUP]);
			sum_i += longint'($signed(hist_model[j].i)) * h;
			sum_q += longint'($signed(hist_model[j].q)) * h;
		end
		res.i = scale_round(sum_i);
		res.q = scale_round(sum_q);
		return res;
	endfunction

	task automatic check_result(input iq_result_t exp, input iq_result_t got);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR t=%0t o_result expected i=%0d q=%0d, got i=%0d q=%0d", $time,
				$signed(exp.i), $signed(exp.q), $signed(got.i), $signed(got.q));
		end
	endtask

	task automatic check_ready(input logic exp, input logic got);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR t=%0t o_ready expected %b, got %b", $time, exp, got);
		end
	endtask

	////////////////////
	// Stimulus tasks
	////////////////////

	task automatic model_take(input iq_sample_t s);
		for (int j = `SHAPER_TAPS - 1; j > 0; j--)
			hist_model[j] = hist_model[j - 1];
		hist_model[0] = s;
		if (checking)
			for (int p = 0; p < `SHAPER_NUP; p++)
				exp_q.push_back(expected_output(p));
	endtask

	// Called on a falling edge, hold keeps valid up while the DUT is busy
	task automatic send_sample(input iq_sample_t s, input int hold);
		while (o_ready !== 1'b1)
			@(negedge i_clk);
		i_valid  = 1'b1;
		i_sample = s;
		sent_count++;
		model_take(s);
		repeat (hold + 1)
			@(negedge i_clk);
		i_valid = 1'b0;
	endtask

	task automatic load_coeff(input coeff_t c);
		i_wr_coeff = 1'b1;
		i_coeff    = c;
		coef_model[wr_ptr_model] = c;
		wr_ptr_model++;
		@(negedge i_clk);
		i_wr_coeff = 1'b0;
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		repeat (4)
			@(negedge i_clk);
		i_reset = 1'b0;
		wr_ptr_model = '0;
	endtask

	// Busy window first, then the four stage pipeline behind the last request
	task automatic drain();
		while (o_ready !== 1'b1)
			@(negedge i_clk);
		repeat (6)
			@(negedge i_clk);
	endtask

	// Outputs built on unknown history are counted but not compared
	task automatic prime_history();
		checking = 1'b0;
		repeat (`SHAPER_TAPS)
			send_sample('0, 0);
		drain();
		checking = 1'b1;
	endtask

	// An impulse of one output step on I, its negative on Q, so outputs read back h in order
	task automatic impulse_response();
		iq_sample_t s;
		s.i = IW'(1 << DROP);
		s.q = IW'(-(1 << DROP));
		send_sample(s, 0);
		repeat (`SHAPER_TAPS - 1)
			send_sample('0, 0);
		drain();
	endtask

	////////////////////
	// Output and ready monitor
	////////////////////

	always @(negedge i_clk)
	begin
		// Ready falls only on a take and must stay low for one full window
		if (busy_cnt != 0)
		begin
			check_ready(logic'(busy_cnt >= NCO), o_ready);
			busy_cnt = (o_ready === 1'b0) ? busy_cnt + 1 : 0;
		end
		else if (o_ready === 1'b0)
		begin
			take_count++;
			busy_cnt = 1;
		end
		if (o_ce === 1'b1)
		begin
			ce_count++;
			if (checking && (exp_q.size() == 0))
			begin
				other_errors++;
				$display("Output strobe at %0t ns with no expected result", $time);
			end
			else if (checking)
				check_result(exp_q.pop_front(), o_result);
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		iq_sample_t s;
		iq_result_t sat_exp;
		i_reset      = 1'b1;
		i_wr_coeff   = 1'b0;
		i_coeff      = '0;
		i_valid      = 1'b0;
		i_sample     = '0;
		checking     = 1'b0;
		wr_ptr_model = '0;
		apply_reset();

		// Impulse response of coefficients 1 to 32
		for (int k = 0; k < NCO; k++)
			load_coeff(coeff_t'(k + 1));
		prime_history();
		impulse_response();

		// Random coefficients and independent random rails
		for (int k = 0; k < NCO; k++)
			load_coeff(coeff_t'($random(seed)));
		for (int k = 0; k < 40; k++)
		begin
			s.i = IW'($random(seed));
			s.q = IW'($random(seed));
			send_sample(s, k % 3);
		end
		drain();

		// Samples held valid deep into the busy window
		for (int k = 0; k < 4; k++)
		begin
			s.i = IW'($random(seed));
			s.q = IW'($random(seed));
			send_sample(s, 20);
		end
		drain();

		// Most negative coefficients, I at negative full scale and Q at positive
		for (int k = 0; k < NCO; k++)
			load_coeff(coeff_t'({1'b1, {(CW - 1){1'b0}}}));
		s.i = {1'b1, {(IW - 1){1'b0}}};
		s.q = {1'b0, {(IW - 1){1'b1}}};
		repeat (10)
			send_sample(s, 0);
		drain();
		sat_exp.i = {1'b0, {(OW - 1){1'b1}}};
		sat_exp.q = {1'b1, {(OW - 1){1'b0}}};
		check_result(sat_exp, o_result);

		// Only the newest tap weighs in, so odd multiples of half a step sit on ties
		for (int k = 0; k < NCO; k++)
			load_coeff(coeff_t'((k < `SHAPER_NUP) ? 1 : 0));
		for (int k = 0; k < 8; k++)
		begin
			s.i = IW'((2 * k + 1) << (DROP - 1));
			s.q = IW'(-((2 * k + 1) << (DROP - 1)));
			send_sample(s, 0);
		end
		drain();

		// Reset in mid load, the next writes start over at h[0]
		for (int k = 0; k < NCO; k++)
			load_coeff(coeff_t'(100 + k));
		for (int k = 0; k < 5; k++)
			load_coeff(coeff_t'(-200 - k));
		apply_reset();
		for (int k = 0; k < 3; k++)
			load_coeff(coeff_t'(300 + k));
		prime_history();
		impulse_response();

		// 33 writes from a fresh pointer, the last lands on h[0] again
		apply_reset();
		for (int k = 0; k <= NCO; k++)
			load_coeff(coeff_t'(-7 * (k + 1)));
		prime_history();
		impulse_response();

		if (exp_q.size() != 0)
		begin
			other_errors++;
			$display("%0d expected results never showed up at the output", exp_q.size());
		end
		if (take_count != sent_count)
		begin
			other_errors++;
			$display("%0d samples were sent but %0d were taken", sent_count, take_count);
		end
		if (ce_count != take_count * `SHAPER_NUP)
		begin
			other_errors++;
			$display("%0d output strobes for %0d taken samples", ce_count, take_count);
		end
		$display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0))
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+include
rtl/shaper_sample_pkg.sv
rtl/shaper_ctrl_pkg.sv
rtl/tap_ram.sv
rtl/tap_sequencer.sv
rtl/iq_mac.sv
rtl/iq_round_sat.sv
rtl/pulse_shaper_top.sv
bench/tb_pulse_shaper.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_pulse_shaper
FILELIST = tb.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
